/* source/ex_defs.svh */
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////

// Data and address width
`define EX_XLEN 32

// Register file has 32 entries
`define EX_REG_AW 5

// Squashed slot targets x0 so nothing is written back
`define EX_BUBBLE_RD 0

`endif

/* source/ex_pkg.sv */
`include "ex_defs.svh"

package ex_pkg;

   typedef logic [`EX_XLEN-1:0]   xdata_t;    // Register values, PC, immediates
   typedef logic [`EX_REG_AW-1:0] reg_addr_t; // Register labels
   typedef logic [2:0]            funct3_t;
   typedef logic [1:0]            wb_sel_t;   // Opaque to this stage

   // Integer ALU operations
   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
      ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
   } alu_op_e;

   // Control transfer kind
   typedef enum logic [1:0] {
      BR_NONE, BR_COND, BR_JAL, BR_JALR
   } br_op_e;

   // Where the latest value of a source register comes from
   typedef enum logic [1:0] {
      FWD_REGFILE, FWD_EX_MEM, FWD_MEM_WB_ALU, FWD_MEM_WB_LOAD
   } fwd_sel_e;

   typedef enum logic [1:0] {
      FAULT_NONE, FAULT_BRANCH_MISALIGN, FAULT_LOAD_MISALIGN, FAULT_STORE_MISALIGN
   } fault_e;

endpackage

/* source/ex_operand_if.sv */
`timescale 1ns/1ps

// Resolved operands, valid in the same cycle they are driven
interface ex_operand_if;
   import ex_pkg::*;

   xdata_t op_a;    // rs1 or PC
   xdata_t op_b;    // rs2 or immediate
   xdata_t rs1_val; // Forwarded rs1, JALR base and compare
   xdata_t rs2_val; // Forwarded rs2, compare and store data

   modport source (
      output op_a,
      output op_b,
      output rs1_val,
      output rs2_val
   );

   modport sink (
      input op_a,
      input op_b,
      input rs1_val,
      input rs2_val
   );

endinterface

/* source/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward (
   input  ex_pkg::reg_addr_t rs1_label_i,
   input  ex_pkg::reg_addr_t rs2_label_i,
   input  ex_pkg::xdata_t    rs1_value_i,
   input  ex_pkg::xdata_t    rs2_value_i,
   input  ex_pkg::xdata_t    pc_i,
   input  ex_pkg::xdata_t    imm_i,
   input  logic              op1_pc_sel_i,
   input  logic              op2_imm_sel_i,
   input  ex_pkg::reg_addr_t rd_ex_mem_i,
   input  ex_pkg::reg_addr_t rd_mem_wb_i,
   input  ex_pkg::xdata_t    alu_out_ex_mem_i,
   input  ex_pkg::xdata_t    alu_out_mem_wb_i,
   input  ex_pkg::xdata_t    rd_data_mem_wb_i,
   input  logic              is_load_mem_wb_i,
   ex_operand_if.source      opnd
);
   import ex_pkg::*;

   fwd_sel_e fwd1_sel;
   fwd_sel_e fwd2_sel;
   xdata_t   rs1_latest;
   xdata_t   rs2_latest;

   ////////////////////////////////////////
   // Hazard detection
   ////////////////////////////////////////

   // Younger result in EX/MEM wins, x0 never forwards
   function automatic fwd_sel_e fwd_select(input reg_addr_t rs);
      fwd_sel_e sel;
      sel = FWD_REGFILE;
      if (rs != '0) begin
         if (rs == rd_ex_mem_i) begin
            sel = FWD_EX_MEM;
         end else if (rs == rd_mem_wb_i) begin
            sel = is_load_mem_wb_i ? FWD_MEM_WB_LOAD : FWD_MEM_WB_ALU;
         end
      end
      return sel;
   endfunction

   function automatic xdata_t fwd_value(input fwd_sel_e sel, input xdata_t rf_val);
      xdata_t val;
      case (sel)
         FWD_EX_MEM:      val = alu_out_ex_mem_i;
         FWD_MEM_WB_ALU:  val = alu_out_mem_wb_i;
         FWD_MEM_WB_LOAD: val = rd_data_mem_wb_i; // Load data, not the address
         default:         val = rf_val;
      endcase
      return val;
   endfunction

   assign fwd1_sel = fwd_select(rs1_label_i);
   assign fwd2_sel = fwd_select(rs2_label_i);

   assign rs1_latest = fwd_value(fwd1_sel, rs1_value_i);
   assign rs2_latest = fwd_value(fwd2_sel, rs2_value_i);

   ////////////////////////////////////////
   // Operand selection
   ////////////////////////////////////////

   assign opnd.rs1_val = rs1_latest;
   assign opnd.rs2_val = rs2_latest;

   assign opnd.op_a = op1_pc_sel_i ? pc_i : rs1_latest;   // AUIPC, JAL
   assign opnd.op_b = op2_imm_sel_i ? imm_i : rs2_latest; // I-type, loads, stores

endmodule

/* source/int_alu.sv */
`timescale 1ns/1ps

module int_alu (
   ex_operand_if.sink      opnd,
   input  ex_pkg::alu_op_e alu_op_i,
   output ex_pkg::xdata_t  result_o
);
   import ex_pkg::*;

   logic [4:0] shamt;
   logic       lt_signed;
   logic       lt_unsigned;

   // Only the low 5 bits count for RV32 shifts
   assign shamt = opnd.op_b[4:0];

   assign lt_signed   = $signed(opnd.op_a) < $signed(opnd.op_b);
   assign lt_unsigned = opnd.op_a < opnd.op_b;

   always_comb begin
      case (alu_op_i)
         ALU_ADD: begin
            result_o = opnd.op_a + opnd.op_b;
         end
         ALU_SUB: begin
            result_o = opnd.op_a - opnd.op_b;
         end
         ALU_SLL: begin
            result_o = opnd.op_a << shamt;
         end
         ALU_SLT: begin
            result_o = xdata_t'(lt_signed);
         end
         ALU_SLTU: begin
            result_o = xdata_t'(lt_unsigned);
         end
         ALU_XOR: begin
            result_o = opnd.op_a ^ opnd.op_b;
         end
         ALU_SRL: begin
            result_o = opnd.op_a >> shamt;
         end
         ALU_SRA: begin
            result_o = xdata_t'($signed(opnd.op_a) >>> shamt); // Sign fill
         end
         ALU_OR: begin
            result_o = opnd.op_a | opnd.op_b;
         end
         ALU_AND: begin
            result_o = opnd.op_a & opnd.op_b;
         end
         ALU_PASS_B: begin
            result_o = opnd.op_b; // LUI
         end
         default: begin
            result_o = '0;
         end
      endcase
   end

endmodule

/* source/branch_resolve.sv */
`timescale 1ns/1ps

module branch_resolve (
   ex_operand_if.sink      opnd,
   input  ex_pkg::br_op_e  br_op_i,
   input  ex_pkg::funct3_t funct3_i,
   input  ex_pkg::xdata_t  pc_i,
   input  ex_pkg::xdata_t  imm_i,
   output logic            taken_o,
   output ex_pkg::xdata_t  target_o,
   output logic            misaligned_o
);
   import ex_pkg::*;

   logic   cond_true;
   xdata_t jalr_sum;

   ////////////////////////////////////////
   // Branch condition
   ////////////////////////////////////////

   always_comb begin
      case (funct3_i)
         3'b000:  cond_true = opnd.rs1_val == opnd.rs2_val;                  // BEQ
         3'b001:  cond_true = opnd.rs1_val != opnd.rs2_val;                  // BNE
         3'b100:  cond_true = $signed(opnd.rs1_val) < $signed(opnd.rs2_val);  // BLT
         3'b101:  cond_true = $signed(opnd.rs1_val) >= $signed(opnd.rs2_val); // BGE
         3'b110:  cond_true = opnd.rs1_val < opnd.rs2_val;                   // BLTU
         3'b111:  cond_true = opnd.rs1_val >= opnd.rs2_val;                  // BGEU
         default: cond_true = 1'b0; // Reserved encodings never branch
      endcase
   end

   always_comb begin
      case (br_op_i)
         BR_COND: taken_o = cond_true;
         BR_JAL:  taken_o = 1'b1;
         BR_JALR: taken_o = 1'b1;
         default: taken_o = 1'b0;
      endcase
   end

   ////////////////////////////////////////
   // Target
   ////////////////////////////////////////

   assign jalr_sum = opnd.rs1_val + imm_i;

   always_comb begin
      if (br_op_i == BR_JALR) begin
         target_o = {jalr_sum[`EX_XLEN-1:1], 1'b0}; // LSB dropped per spec
      end else begin
         target_o = pc_i + imm_i;
      end
   end

   // No compressed support, so targets must be word aligned
   assign misaligned_o = taken_o && target_o[1];

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps
`include "ex_defs.svh"

module execute_stage (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              busywait_i,
   // ID/EX fields
   input  ex_pkg::xdata_t    pc_i,
   input  ex_pkg::xdata_t    imm_i,
   input  ex_pkg::xdata_t    rs1_value_i,
   input  ex_pkg::xdata_t    rs2_value_i,
   input  ex_pkg::reg_addr_t rs1_label_i,
   input  ex_pkg::reg_addr_t rs2_label_i,
   input  ex_pkg::reg_addr_t rd_i,
   input  ex_pkg::funct3_t   funct3_i,
   input  ex_pkg::wb_sel_t   wb_sel_i,
   input  ex_pkg::alu_op_e   alu_op_i,
   input  ex_pkg::br_op_e    br_op_i,
   input  logic              op1_pc_sel_i,
   input  logic              op2_imm_sel_i,
   input  logic              is_load_i,
   input  logic              is_store_i,
   // MEM/WB forwarding source
   input  ex_pkg::reg_addr_t rd_mem_wb_i,
   input  ex_pkg::xdata_t    alu_out_mem_wb_i,
   input  ex_pkg::xdata_t    rd_data_mem_wb_i,
   input  logic              is_load_mem_wb_i,
   input  ex_pkg::xdata_t    trap_vector_i,
   // EX/MEM register
   output ex_pkg::xdata_t    alu_out_o,
   output ex_pkg::xdata_t    rs2_o,
   output ex_pkg::reg_addr_t rd_o,
   output ex_pkg::xdata_t    pc_o,
   output ex_pkg::funct3_t   funct3_o,
   output ex_pkg::wb_sel_t   wb_sel_o,
   output logic              is_load_o,
   output logic              is_store_o,
   output logic              branching_o,
   output ex_pkg::xdata_t    branch_target_o,
   output logic              exception_o,
   output ex_pkg::fault_e    fault_o
);
   import ex_pkg::*;

   ex_operand_if opnd ();

   xdata_t alu_res;
   logic   br_taken;
   xdata_t br_target;
   logic   br_misaligned;
   logic   addr_misaligned;
   logic   mem_misaligned;
   logic   ex_en;
   logic   fault;
   fault_e fault_cause;

   // Next state of the EX/MEM register
   xdata_t    alu_out_d, rs2_d, pc_d, target_d;
   funct3_t   funct3_d;
   wb_sel_t   wb_sel_d;
   reg_addr_t rd_d;
   logic      load_d, store_d, branching_d, exception_d;
   fault_e    fault_d;

   operand_forward u_operand_forward (
      .rs1_label_i      (rs1_label_i),
      .rs2_label_i      (rs2_label_i),
      .rs1_value_i      (rs1_value_i),
      .rs2_value_i      (rs2_value_i),
      .pc_i             (pc_i),
      .imm_i            (imm_i),
      .op1_pc_sel_i     (op1_pc_sel_i),
      .op2_imm_sel_i    (op2_imm_sel_i),
      .rd_ex_mem_i      (rd_o),      // Own register is the EX/MEM source
      .rd_mem_wb_i      (rd_mem_wb_i),
      .alu_out_ex_mem_i (alu_out_o),
      .alu_out_mem_wb_i (alu_out_mem_wb_i),
      .rd_data_mem_wb_i (rd_data_mem_wb_i),
      .is_load_mem_wb_i (is_load_mem_wb_i),
      .opnd             (opnd.source)
   );

   int_alu u_int_alu (
      .opnd     (opnd.sink),
      .alu_op_i (alu_op_i),
      .result_o (alu_res)
   );

   branch_resolve u_branch_resolve (
      .opnd         (opnd.sink),
      .br_op_i      (br_op_i),
      .funct3_i     (funct3_i),
      .pc_i         (pc_i),
      .imm_i        (imm_i),
      .taken_o      (br_taken),
      .target_o     (br_target),
      .misaligned_o (br_misaligned)
   );

   ////////////////////////////////////////
   // Fault detection
   ////////////////////////////////////////

   // Access size from funct3[1:0], sign bit ignored
   always_comb begin
      case (funct3_i[1:0])
         2'b00:   addr_misaligned = 1'b0;
         2'b01:   addr_misaligned = alu_res[0];
         default: addr_misaligned = |alu_res[1:0];
      endcase
   end

   assign mem_misaligned = (is_load_i || is_store_i) && addr_misaligned;

   // Slot behind a redirect is dead
   assign ex_en = !branching_o;
   assign fault = br_misaligned || mem_misaligned;

   always_comb begin
      if (br_misaligned) begin
         fault_cause = FAULT_BRANCH_MISALIGN; // Takes priority
      end else if (mem_misaligned && is_load_i) begin
         fault_cause = FAULT_LOAD_MISALIGN;
      end else if (mem_misaligned) begin
         fault_cause = FAULT_STORE_MISALIGN;
      end else begin
         fault_cause = FAULT_NONE;
      end
   end

   ////////////////////////////////////////
   // EX/MEM next state
   ////////////////////////////////////////

   always_comb begin
      if (ex_en) begin
         alu_out_d   = (br_op_i == BR_JAL || br_op_i == BR_JALR) ? pc_i + 32'd4 : alu_res;
         rs2_d       = opnd.rs2_val;
         pc_d        = pc_i;
         funct3_d    = funct3_i;
         wb_sel_d    = wb_sel_i;
         rd_d        = rd_i;
         load_d      = is_load_i && !fault;
         store_d     = is_store_i && !fault;
         branching_d = br_taken || fault;
         target_d    = fault ? trap_vector_i : br_target;
         exception_d = fault;
         fault_d     = fault_cause;
      end else begin
         // Bubble
         alu_out_d   = '0;
         rs2_d       = '0;
         pc_d        = '0;
         funct3_d    = '0;
         wb_sel_d    = '0;
         rd_d        = reg_addr_t'(`EX_BUBBLE_RD);
         load_d      = 1'b0;
         store_d     = 1'b0;
         branching_d = exception_o; // Fault in previous slot redirects once more
         target_d    = trap_vector_i;
         exception_d = 1'b0;
         fault_d     = FAULT_NONE;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rd_o        <= reg_addr_t'(`EX_BUBBLE_RD);
         is_load_o   <= 1'b0;
         is_store_o  <= 1'b0;
         branching_o <= 1'b0;
         exception_o <= 1'b0;
         fault_o     <= FAULT_NONE;
      end else if (!busywait_i) begin
         rd_o        <= rd_d;
         is_load_o   <= load_d;
         is_store_o  <= store_d;
         branching_o <= branching_d;
         exception_o <= exception_d;
         fault_o     <= fault_d;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!busywait_i) begin
         alu_out_o       <= alu_out_d;
         rs2_o           <= rs2_d;
         pc_o            <= pc_d;
         funct3_o        <= funct3_d;
         wb_sel_o        <= wb_sel_d;
         branch_target_o <= target_d;
      end
   end

endmodule

/* test/execute_stage_chk.sv */
`timescale 1ns/1ps

module execute_stage_chk (
   input logic              clk_i,
   input logic              rst_i,
   input logic              busywait_i,
   input ex_pkg::xdata_t    alu_out_i,
   input ex_pkg::xdata_t    rs2_i,
   input ex_pkg::reg_addr_t rd_i,
   input ex_pkg::xdata_t    pc_i,
   input ex_pkg::funct3_t   funct3_i,
   input ex_pkg::wb_sel_t   wb_sel_i,
   input logic              is_load_i,
   input logic              is_store_i,
   input logic              branching_i,
   input ex_pkg::xdata_t    branch_target_i,
   input logic              exception_i,
   input ex_pkg::fault_e    fault_i
);

   int fail_count = 0;

   //////////////////////////////////////// 
   // Stall holds the whole EX/MEM register
   ////////////////////////////////////////

   hold_on_busywait: assert property (@(posedge clk_i) disable iff (rst_i)
      busywait_i |=> $stable(alu_out_i) && $stable(rs2_i) && $stable(rd_i) &&
                     $stable(pc_i) && $stable(funct3_i) && $stable(wb_sel_i) &&
                     $stable(is_load_i) && $stable(is_store_i) && $stable(branching_i) &&
                     $stable(branch_target_i) && $stable(exception_i) && $stable(fault_i))
   else begin
      fail_count++;
      $error("EX/MEM register changed while busywait was high");
   end

   // Squashed slot never raises a new exception
   bubble_no_exception: assert property (@(posedge clk_i) disable iff (rst_i)
      branching_i && !busywait_i |=> !exception_i)
   else begin
      fail_count++;
      $error("Exception raised in a squashed slot");
   end

   load_store_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
      !(is_load_i && is_store_i))
   else begin
      fail_count++;
      $error("Load and store flags high together");
   end

endmodule

bind execute_stage execute_stage_chk u_chk (
   .clk_i           (clk_i),
   .rst_i           (rst_i),
   .busywait_i      (busywait_i),
   .alu_out_i       (alu_out_o),
   .rs2_i           (rs2_o),
   .rd_i            (rd_o),
   .pc_i            (pc_o),
   .funct3_i        (funct3_o),
   .wb_sel_i        (wb_sel_o),
   .is_load_i       (is_load_o),
   .is_store_i      (is_store_o),
   .branching_i     (branching_o),
   .branch_target_i (branch_target_o),
   .exception_i     (exception_o),
   .fault_i         (fault_o)
);

/* test/execute_stage_tb.sv */
`timescale 1ns/1ps

module execute_stage_tb;
   import ex_pkg::*;

   localparam int CLK_PERIOD = 8;
   localparam int RST_CYCLES = 5;
   localparam int NUM_CYCLES = 5000;

   logic      clk_i;
   logic      rst_i;
   logic      busywait_i;
   xdata_t    pc_i, imm_i, rs1_value_i, rs2_value_i;
   reg_addr_t rs1_label_i, rs2_label_i, rd_i;
   funct3_t   funct3_i;
   wb_sel_t   wb_sel_i;
   alu_op_e   alu_op_i;
   br_op_e    br_op_i;
   logic      op1_pc_sel_i, op2_imm_sel_i, is_load_i, is_store_i;
   reg_addr_t rd_mem_wb_i;
   xdata_t    alu_out_mem_wb_i, rd_data_mem_wb_i, trap_vector_i;
   logic      is_load_mem_wb_i;

   xdata_t    alu_out_o, rs2_o, pc_o, branch_target_o;
   reg_addr_t rd_o;
   funct3_t   funct3_o;
   wb_sel_t   wb_sel_o;
   logic      is_load_o, is_store_o, branching_o, exception_o;
   fault_e    fault_o;

   // Reference copy of the EX/MEM register
   xdata_t    m_alu_out, m_rs2, m_pc, m_target;
   reg_addr_t m_rd;
   funct3_t   m_funct3;
   wb_sel_t   m_wb_sel;
   logic      m_load, m_store, m_branching, m_exception;
   fault_e    m_fault;
   logic      m_bubble;   // Datapath fields of a bubble are don't care
   logic      m_dp_valid; // Datapath loaded at least once after reset

   integer seed = 32'hf943e5a3;
   int     cyc;

   execute_stage i_dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // Watchdog
   initial begin
      #((RST_CYCLES + NUM_CYCLES + 20) * CLK_PERIOD);
      $display("Run did not complete in the expected time, watchdog expired");
      $display("TESTBENCH FAILED");
      $fatal(1, "Watchdog timeout");
   end

   ////////////////////////////////////////
   // Random helpers
   ////////////////////////////////////////

   function automatic int unsigned rnd(input int unsigned n);
      int unsigned r;
      r = $unsigned($random(seed));
      return r % n;
   endfunction

   function automatic xdata_t rnd_value();
      xdata_t v;
      v = xdata_t'($random(seed));
      if (rnd(2) == 0) v[1:0] = 2'b00; // Aligned half the time
      return v;
   endfunction

   function automatic xdata_t rnd_imm();
      xdata_t v;
      v = xdata_t'($random(seed));
      v[31:12] = {20{v[11]}};
      if (rnd(4) != 0) v[1:0] = 2'b00;
      return v;
   endfunction

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   function automatic logic lt_signed(input xdata_t a, input xdata_t b);
      // Different signs decide on their own
      return (a[31] != b[31]) ? a[31] : (a < b);
   endfunction

   function automatic xdata_t alu_ref(input alu_op_e op, input xdata_t a, input xdata_t b);
      logic [4:0] sh;
      sh = b[4:0];
      case (op)
         ALU_ADD:    return a + b;
         ALU_SUB:    return a - b;
         ALU_SLL:    return a << sh;
         ALU_SLT:    return lt_signed(a, b) ? 32'd1 : 32'd0;
         ALU_SLTU:   return (a < b) ? 32'd1 : 32'd0;
         ALU_XOR:    return a ^ b;
         ALU_SRL:    return a >> sh;
         ALU_SRA:    return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
         ALU_OR:     return a | b;
         ALU_AND:    return a & b;
         ALU_PASS_B: return b;
         default:    return 32'd0;
      endcase
   endfunction

   // EX/MEM beats MEM/WB, x0 reads the register file
   function automatic xdata_t fwd_ref(input reg_addr_t rs, input xdata_t rf);
      if (rs == 5'd0) return rf;
      if (rs == m_rd) return m_alu_out;
      if (rs == rd_mem_wb_i) return is_load_mem_wb_i ? rd_data_mem_wb_i : alu_out_mem_wb_i;
      return rf;
   endfunction

   task automatic model_reset();
      m_alu_out   = '0;
      m_rd        = '0;
      m_load      = 1'b0;
      m_store     = 1'b0;
      m_branching = 1'b0;
      m_exception = 1'b0;
      m_fault     = FAULT_NONE;
      m_bubble    = 1'b0;
      m_dp_valid  = 1'b0;
   endtask

   task automatic model_step();
      xdata_t r1, r2, a, b, res, tgt;
      logic   cond, taken, br_mis, mem_mis, flt;
      if (!busywait_i && m_branching) begin
         m_branching = m_exception; // Pending fault redirects once more
         m_target    = trap_vector_i;
         m_rd        = '0;
         m_load      = 1'b0;
         m_store     = 1'b0;
         m_exception = 1'b0;
         m_fault     = FAULT_NONE;
         m_bubble    = 1'b1;
         m_dp_valid  = 1'b1;
      end else if (!busywait_i) begin
         r1  = fwd_ref(rs1_label_i, rs1_value_i);
         r2  = fwd_ref(rs2_label_i, rs2_value_i);
         a   = op1_pc_sel_i ? pc_i : r1;
         b   = op2_imm_sel_i ? imm_i : r2;
         res = alu_ref(alu_op_i, a, b);
         case (funct3_i)
            3'b000:  cond = (r1 == r2);
            3'b001:  cond = (r1 != r2);
            3'b100:  cond = lt_signed(r1, r2);
            3'b101:  cond = !lt_signed(r1, r2);
            3'b110:  cond = (r1 < r2);
            3'b111:  cond = (r1 >= r2);
            default: cond = 1'b0;
         endcase
         taken = (br_op_i == BR_COND) ? cond : (br_op_i == BR_JAL || br_op_i == BR_JALR);
         tgt   = (br_op_i == BR_JALR) ? ((r1 + imm_i) & ~32'd1) : (pc_i + imm_i);
         br_mis  = taken && tgt[1];
         mem_mis = (is_load_i || is_store_i) &&
                   ((funct3_i[1:0] == 2'b01 && res[0]) ||
                    (funct3_i[1:0] == 2'b10 && res[1:0] != 2'b00));
         flt = br_mis || mem_mis;
         m_alu_out   = (br_op_i == BR_JAL || br_op_i == BR_JALR) ? pc_i + 32'd4 : res;
         m_rs2       = r2;
         m_pc        = pc_i;
         m_funct3    = funct3_i;
         m_wb_sel    = wb_sel_i;
         m_rd        = rd_i;
         m_load      = is_load_i && !flt;
         m_store     = is_store_i && !flt;
         m_branching = taken || flt;
         m_target    = flt ? trap_vector_i : tgt;
         m_exception = flt;
         if (br_mis) m_fault = FAULT_BRANCH_MISALIGN;
         else if (mem_mis && is_load_i) m_fault = FAULT_LOAD_MISALIGN;
         else if (mem_mis) m_fault = FAULT_STORE_MISALIGN;
         else m_fault = FAULT_NONE;
         m_bubble   = 1'b0;
         m_dp_valid = 1'b1;
      end
   endtask

   ////////////////////////////////////////
   // Stimulus and checks
   ////////////////////////////////////////

   task automatic draw_instr();
      int unsigned f;
      pc_i             = rnd_value() & ~32'd3;
      imm_i            = rnd_imm();
      rs1_value_i      = rnd_value();
      rs2_value_i      = rnd_value();
      rs1_label_i      = reg_addr_t'(rnd(8)); // x0..x7 for frequent hazards
      rs2_label_i      = reg_addr_t'(rnd(8));
      rd_i             = reg_addr_t'(rnd(8));
      wb_sel_i         = wb_sel_t'(rnd(4));
      funct3_i         = funct3_t'(rnd(8));
      alu_op_i         = alu_op_e'(rnd(11));
      br_op_i          = BR_NONE;
      op1_pc_sel_i     = (rnd(2) == 1);
      op2_imm_sel_i    = (rnd(2) == 1);
      is_load_i        = 1'b0;
      is_store_i       = 1'b0;
      rd_mem_wb_i      = reg_addr_t'(rnd(8));
      alu_out_mem_wb_i = rnd_value();
      rd_data_mem_wb_i = rnd_value();
      is_load_mem_wb_i = (rnd(2) == 1);
      trap_vector_i    = rnd_value() & ~32'd3;
      case (rnd(10))
         4, 5: begin // Load, LB..LHU
            f = rnd(5);
            is_load_i     = 1'b1;
            op1_pc_sel_i  = 1'b0;
            op2_imm_sel_i = 1'b1;
            alu_op_i      = ALU_ADD;
            funct3_i = funct3_t'(f < 3 ? f : f + 1);
         end
         6: begin
            is_store_i    = 1'b1;
            op1_pc_sel_i  = 1'b0;
            op2_imm_sel_i = 1'b1;
            alu_op_i      = ALU_ADD;
            funct3_i = funct3_t'(rnd(3));
         end
         7: begin // Valid branch encodings only
            f = rnd(6);
            br_op_i       = BR_COND;
            op1_pc_sel_i  = 1'b0;
            op2_imm_sel_i = 1'b0;
            funct3_i = funct3_t'(f < 2 ? f : f + 2);
         end
         8: begin
            br_op_i       = BR_JAL;
            op1_pc_sel_i  = 1'b1;
            op2_imm_sel_i = 1'b1;
            alu_op_i      = ALU_ADD;
         end
         9: begin
            br_op_i       = BR_JALR;
            op1_pc_sel_i  = 1'b0;
            op2_imm_sel_i = 1'b1;
            alu_op_i      = ALU_ADD;
         end
         default: ;
      endcase
   endtask

   task automatic check_field(input string name, input xdata_t act, input xdata_t exp);
      assert (act === exp) else begin
         $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
         $display("TESTBENCH FAILED");
         $fatal(1, "Output mismatch");
      end
   endtask

   task automatic compare_outputs();
      check_field("rd_o", xdata_t'(rd_o), xdata_t'(m_rd));
      check_field("is_load_o", xdata_t'(is_load_o), xdata_t'(m_load));
      check_field("is_store_o", xdata_t'(is_store_o), xdata_t'(m_store));
      check_field("branching_o", xdata_t'(branching_o), xdata_t'(m_branching));
      check_field("exception_o", xdata_t'(exception_o), xdata_t'(m_exception));
      check_field("fault_o", xdata_t'(fault_o), xdata_t'(m_fault));
      if (m_branching) check_field("branch_target_o", branch_target_o, m_target);
      if (m_dp_valid && !m_bubble) begin
         check_field("alu_out_o", alu_out_o, m_alu_out);
         check_field("rs2_o", rs2_o, m_rs2);
         check_field("pc_o", pc_o, m_pc);
         check_field("funct3_o", xdata_t'(funct3_o), xdata_t'(m_funct3));
         check_field("wb_sel_o", xdata_t'(wb_sel_o), xdata_t'(m_wb_sel));
      end
   endtask

   initial begin
      busywait_i = 1'b0;
      rst_i      = 1'b1;
      draw_instr();
      {pc_i, imm_i, rs1_value_i, rs2_value_i, trap_vector_i} = '0;
      model_reset();
      repeat (RST_CYCLES) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      compare_outputs(); // Control outputs inactive after reset
      for (cyc = 0; cyc < NUM_CYCLES; cyc++) begin
         if (!busywait_i) draw_instr(); // ID/EX held during a stall
         busywait_i = (rnd(5) == 0);
         model_step();
         @(posedge clk_i);
         #1;
         compare_outputs();
      end
      if (i_dut.u_chk.fail_count == 0) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         $display("TESTBENCH FAILED");
         $fatal(1, "Bound assertions reported %0d failures", i_dut.u_chk.fail_count);
      end
   end

endmodule

/* tb.f */
+incdir+source
source/ex_pkg.sv
source/ex_operand_if.sv
source/operand_forward.sv
source/int_alu.sv
source/branch_resolve.sv
source/execute_stage.sv
test/execute_stage_chk.sv
test/execute_stage_tb.sv

/* Makefile */
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= execute_stage_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= TESTBENCH PASSED

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
HEADERS := $(wildcard source/*.svh test/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
